// File: rtl/sm_dim_pkg.sv
package sm_dim_pkg;

  // subgraph size limits
  localparam int MAX_NODES = 16;
  localparam int CNT_W     = 5;

  // count table
  localparam int NUM_GROUPS = 8;
  localparam int GRP_W      = 3;

  // queue depths
  localparam int COEF_DEPTH     = 32;
  localparam int DIVIDEND_DEPTH = 32;
  localparam int DIVISOR_DEPTH  = 4;
  localparam int ALPHA_DEPTH    = 32;

  // alpha depth less divider latency less one, so the
  // results still in flight always find room
  localparam int ALPHA_AF_LEVEL = 18;

endpackage

// File: rtl/sm_fxp_pkg.sv
package sm_fxp_pkg;

  // coefficient is an unsigned exponent, 0 to 15
  localparam int COEF_W = 4;

  // weight 2^e
  localparam int EXP_W = 16;

  // one weight plus headroom for a full subgraph
  localparam int SUM_W = EXP_W + $clog2(sm_dim_pkg::MAX_NODES);

  // alpha is 1.ALPHA_FRAC unsigned, truncated
  localparam int ALPHA_FRAC = 12;
  localparam int ALPHA_W    = ALPHA_FRAC + 1;

  // one pipeline stage per quotient bit
  localparam int DIV_LAT = ALPHA_W;

  // sum queue word holds {node count, sum}
  localparam int DIVISOR_W = sm_dim_pkg::CNT_W + SUM_W;

endpackage

// File: rtl/fifo_if.sv
`timescale 1ns/10ps

interface fifo_if #(
  parameter int W = 8
) ();

  // write side
  logic [W-1:0] din;
  logic         wr;
  logic         full;
  logic         afull;

  // read side, first word fall through
  logic [W-1:0] dout;
  logic         empty;
  logic         rd;

  modport producer (output din, output wr, input full, input afull);

  modport consumer (input dout, input empty, output rd);

  modport fifo (
    input  din, input  wr, input  rd,
    output full, output afull, output dout, output empty
  );

endinterface

// File: rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
  parameter int W        = 8,
  parameter int DEPTH    = 16,
  parameter int AF_LEVEL = 12
) (
  input  logic clk,
  input  logic rst_n,
  fifo_if.fifo f
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  logic [W-1:0]     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;
  logic             do_wr;
  logic             do_rd;

  // writes while full and reads while empty are dropped
  assign do_wr = f.wr && !f.full;
  assign do_rd = f.rd && !f.empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= f.din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   occ <= occ + OCC_W'(1);
        2'b01:   occ <= occ - OCC_W'(1);
        default: occ <= occ;
      endcase
    end
  end

  // head word shows without a read
  assign f.dout = mem[rd_ptr];

  // flags from occupancy
  assign f.empty = (occ == '0);
  assign f.full  = (occ == OCC_W'(DEPTH));
  assign f.afull = (occ >= OCC_W'(AF_LEVEL));

endmodule

// File: rtl/node_count_ram.sv
`timescale 1ns/10ps

module node_count_ram (
  input  logic                         clk,
  input  logic                         cfg_wr,
  input  logic [sm_dim_pkg::GRP_W-1:0] cfg_addr,
  input  logic [sm_dim_pkg::CNT_W-1:0] cfg_count,
  input  logic [sm_dim_pkg::GRP_W-1:0] grp_addr,
  output logic [sm_dim_pkg::CNT_W-1:0] node_count
);
  import sm_dim_pkg::*;

  logic [CNT_W-1:0] mem [NUM_GROUPS];

  // config port
  always_ff @(posedge clk) begin
    if (cfg_wr) begin
      mem[cfg_addr] <= cfg_count;
    end
  end

  // registered read, write-first on an address match
  always_ff @(posedge clk) begin
    if (cfg_wr && (cfg_addr == grp_addr)) begin
      node_count <= cfg_count;
    end else begin
      node_count <= mem[grp_addr];
    end
  end

endmodule

// File: rtl/fxp_div_pipe.sv
`timescale 1ns/10ps

module fxp_div_pipe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid,
  input  logic [sm_fxp_pkg::EXP_W-1:0]   dividend,
  input  logic [sm_fxp_pkg::SUM_W-1:0]   divisor,
  output logic                           ready,
  output logic [sm_fxp_pkg::ALPHA_W-1:0] quotient
);
  import sm_fxp_pkg::*;

  // Restoring division of (dividend << ALPHA_FRAC) by divisor. The
  // shifted-in fraction zeros come from doubling the remainder at each
  // stage. Needs dividend <= divisor so the quotient fits 1.ALPHA_FRAC.
  for (genvar s = 0; s < DIV_LAT; s++) begin : g_stage
    logic [SUM_W:0]     part;
    logic [SUM_W:0]     diff;
    logic [SUM_W-1:0]   dsr;
    logic [ALPHA_W-1:0] quo;
    logic               vld;
    logic               ge;
    logic [SUM_W-1:0]   rem_r;
    logic [SUM_W-1:0]   dsr_r;
    logic [ALPHA_W-1:0] quo_r;
    logic               vld_r;

    if (s == 0) begin : g_first
      // integer bit decided on the raw dividend
      assign part = {{(SUM_W + 1 - EXP_W){1'b0}}, dividend};
      assign dsr  = divisor;
      assign quo  = '0;
      assign vld  = valid;
    end else begin : g_next
      assign part = {g_stage[s-1].rem_r, 1'b0};
      assign dsr  = g_stage[s-1].dsr_r;
      assign quo  = g_stage[s-1].quo_r;
      assign vld  = g_stage[s-1].vld_r;
    end

    assign diff = part - {1'b0, dsr};
    assign ge   = (part >= {1'b0, dsr});

    always_ff @(posedge clk) begin
      rem_r <= ge ? diff[SUM_W-1:0] : part[SUM_W-1:0];
      dsr_r <= dsr;
      // msb first
      quo_r <= {quo[ALPHA_W-2:0], ge};
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_r <= 1'b0;
      end else begin
        vld_r <= vld;
      end
    end
  end

  assign quotient = g_stage[DIV_LAT-1].quo_r;
  assign ready    = g_stage[DIV_LAT-1].vld_r;

endmodule

// File: rtl/softmax.sv
`timescale 1ns/10ps

module softmax (
  input  logic                         clk,
  input  logic                         rst_n,
  fifo_if.consumer                     coef_q,
  output logic [sm_dim_pkg::GRP_W-1:0] grp_addr,
  input  logic [sm_dim_pkg::CNT_W-1:0] node_count,
  fifo_if.producer                     alpha_q
);
  import sm_fxp_pkg::*;
  import sm_dim_pkg::*;

  fifo_if #(.W(EXP_W))     dividend_q ();
  fifo_if #(.W(DIVISOR_W)) divisor_q ();

  logic [EXP_W-1:0]   weight;
  logic [CNT_W-1:0]   node_idx;
  logic [CNT_W-1:0]   count_r;
  logic [CNT_W-1:0]   cur_count;
  logic [SUM_W-1:0]   sum_r;
  logic [GRP_W-1:0]   grp_r;
  logic [GRP_W-1:0]   grp_nxt;
  logic               first_node;
  logic               last_node;
  logic               pop;

  logic [CNT_W-1:0]   div_idx;
  logic [CNT_W-1:0]   div_count;
  logic [SUM_W-1:0]   div_divisor;
  logic               div_last;
  logic               div_valid;
  logic               div_ready;
  logic [ALPHA_W-1:0] div_quotient;

  sync_fifo #(
    .W        (EXP_W),
    .DEPTH    (DIVIDEND_DEPTH),
    .AF_LEVEL (DIVIDEND_DEPTH)
  ) u_dividend_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (dividend_q)
  );

  sync_fifo #(
    .W        (DIVISOR_W),
    .DEPTH    (DIVISOR_DEPTH),
    .AF_LEVEL (DIVISOR_DEPTH)
  ) u_divisor_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (divisor_q)
  );

  // exp stage
  assign weight = EXP_W'(1) << coef_q.dout;

  // table count is live on the first node, latched after that
  assign first_node = (node_idx == '0);
  assign cur_count  = first_node ? node_count : count_r;
  assign last_node  = (node_idx + CNT_W'(1) == cur_count);

  // the sum word only needs room on the last node
  assign pop = !coef_q.empty && !dividend_q.full && !(last_node && divisor_q.full);
  assign coef_q.rd = pop;

  // address steps ahead so the next count is ready after the edge
  assign grp_nxt  = (grp_r == GRP_W'(NUM_GROUPS - 1)) ? '0 : grp_r + GRP_W'(1);
  assign grp_addr = (pop && last_node) ? grp_nxt : grp_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_idx <= '0;
      count_r  <= '0;
      sum_r    <= '0;
      grp_r    <= '0;
    end else if (pop) begin
      if (first_node) begin
        count_r <= node_count;
      end
      if (last_node) begin
        node_idx <= '0;
        sum_r    <= '0;
        grp_r    <= grp_nxt;
      end else begin
        node_idx <= node_idx + CNT_W'(1);
        sum_r    <= sum_r + SUM_W'(weight);
      end
    end
  end

  assign dividend_q.din = weight;
  assign dividend_q.wr  = pop;
  assign divisor_q.din  = {cur_count, sum_r + SUM_W'(weight)};
  assign divisor_q.wr   = pop && last_node;

  // back end, divisor head belongs to the oldest weight
  assign {div_count, div_divisor} = divisor_q.dout;
  assign div_valid = !dividend_q.empty && !divisor_q.empty && !alpha_q.afull;
  assign div_last  = (div_idx + CNT_W'(1) == div_count);

  assign dividend_q.rd = div_valid;
  assign divisor_q.rd  = div_valid && div_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_idx <= '0;
    end else if (div_valid) begin
      div_idx <= div_last ? '0 : div_idx + CNT_W'(1);
    end
  end

  fxp_div_pipe u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid    (div_valid),
    .dividend (dividend_q.dout),
    .divisor  (div_divisor),
    .ready    (div_ready),
    .quotient (div_quotient)
  );

  // no stall, afull credit keeps room for everything in flight
  assign alpha_q.din = div_quotient;
  assign alpha_q.wr  = div_ready;

endmodule

// File: rtl/gat_softmax_top.sv
`timescale 1ns/10ps

module gat_softmax_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [sm_fxp_pkg::COEF_W-1:0]  coef_din,
  input  logic                           coef_wr,
  output logic                           coef_full,
  output logic [sm_fxp_pkg::ALPHA_W-1:0] alpha_dout,
  input  logic                           alpha_rd,
  output logic                           alpha_empty,
  input  logic                           cfg_wr,
  input  logic [sm_dim_pkg::GRP_W-1:0]   cfg_addr,
  input  logic [sm_dim_pkg::CNT_W-1:0]   cfg_count
);
  import sm_fxp_pkg::*;
  import sm_dim_pkg::*;

  fifo_if #(.W(COEF_W))  coef_q ();
  fifo_if #(.W(ALPHA_W)) alpha_q ();

  logic [GRP_W-1:0] grp_addr;
  logic [CNT_W-1:0] node_count;

  // coefficient stream in
  assign coef_q.din = coef_din;
  assign coef_q.wr  = coef_wr;
  assign coef_full  = coef_q.full;

  // alpha stream out
  assign alpha_dout  = alpha_q.dout;
  assign alpha_q.rd  = alpha_rd;
  assign alpha_empty = alpha_q.empty;

  sync_fifo #(
    .W        (COEF_W),
    .DEPTH    (COEF_DEPTH),
    .AF_LEVEL (COEF_DEPTH)
  ) u_coef_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (coef_q)
  );

  node_count_ram u_ncount (
    .clk        (clk),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_count  (cfg_count),
    .grp_addr   (grp_addr),
    .node_count (node_count)
  );

  softmax u_softmax (
    .clk        (clk),
    .rst_n      (rst_n),
    .coef_q     (coef_q),
    .grp_addr   (grp_addr),
    .node_count (node_count),
    .alpha_q    (alpha_q)
  );

  sync_fifo #(
    .W        (ALPHA_W),
    .DEPTH    (ALPHA_DEPTH),
    .AF_LEVEL (ALPHA_AF_LEVEL)
  ) u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (alpha_q)
  );

endmodule

// File: testbench/gat_softmax_chk.sv
`timescale 1ns/10ps

module gat_softmax_chk (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         div_valid,
  input logic                         alpha_wr,
  input logic                         alpha_full,
  input logic [sm_fxp_pkg::EXP_W-1:0] dividend,
  input logic [sm_fxp_pkg::SUM_W-1:0] div_divisor
);

  int fail_count = 0;

  // afull credit leaves room for every result in flight
  a_no_alpha_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) alpha_wr |-> !alpha_full
  ) else begin
    $error("output FIFO written while full");
    fail_count++;
  end

  // divisor head must belong to the issuing weight
  a_dividend_le_divisor: assert property (
    @(posedge clk) disable iff (!rst_n) div_valid |-> (dividend <= div_divisor)
  ) else begin
    $error("weight at issue exceeds its subgraph sum");
    fail_count++;
  end

  // a zero sum means a lost or corrupt divisor word
  a_divisor_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) div_valid |-> (div_divisor != '0)
  ) else begin
    $error("division issued with zero divisor");
    fail_count++;
  end

endmodule

bind softmax gat_softmax_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .div_valid   (div_valid),
  .alpha_wr    (alpha_q.wr),
  .alpha_full  (alpha_q.full),
  .dividend    (dividend_q.dout),
  .div_divisor (div_divisor)
);

// File: testbench/tb_gat_softmax.sv
`timescale 1ns/10ps

module tb_gat_softmax;
  import sm_fxp_pkg::*;
  import sm_dim_pkg::*;

  logic               clk;
  logic               rst_n;
  logic [COEF_W-1:0]  coef_din;
  logic               coef_wr;
  logic               coef_full;
  logic [ALPHA_W-1:0] alpha_dout;
  logic               alpha_rd;
  logic               alpha_empty;
  logic               cfg_wr;
  logic [GRP_W-1:0]   cfg_addr;
  logic [CNT_W-1:0]   cfg_count;

  integer seed = 64037;
  int     tbl [NUM_GROUPS];
  int     grp = 0;
  int     send_q [$];
  int     exp_q [$];
  int     cycles = 0;
  int     coef_total = 0;
  int     limit = 2000;
  int     checks = 0;
  int     errors = 0;
  int     test_err = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  bit     rd_hold;
  bit     rd_random;
  bit     wr_random;
  bit     full_seen;

  gat_softmax_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .coef_din    (coef_din),
    .coef_wr     (coef_wr),
    .coef_full   (coef_full),
    .alpha_dout  (alpha_dout),
    .alpha_rd    (alpha_rd),
    .alpha_empty (alpha_empty),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_count   (cfg_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // limit grows as coefficients are queued
  initial begin : watchdog
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d results still missing", cycles, exp_q.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic note_error();
    errors++;
    test_err++;
  endtask

  task automatic check_alpha();
    int expv;
    checks++;
    if (exp_q.size() == 0) begin
      $display("extra result 0x%h came out when none was expected", alpha_dout);
      note_error();
    end else begin
      expv = exp_q.pop_front();
      if (alpha_dout !== ALPHA_W'(expv)) begin
        $display("FAILED alpha_dout expected 0x%h actual 0x%h", ALPHA_W'(expv), alpha_dout);
        note_error();
      end
    end
  endtask

  // one clock, inputs change 2 ns after the edge
  task automatic run_cycle();
    @(posedge clk);
    #2;
    if (coef_full) begin
      full_seen = 1'b1;
    end
    if (send_q.size() > 0 && !coef_full && (!wr_random || ($random(seed) & 3) != 0)) begin
      coef_din = COEF_W'(send_q.pop_front());
      coef_wr  = 1'b1;
    end else begin
      coef_wr = 1'b0;
    end
    if (!rd_hold && !alpha_empty && (!rd_random || ($random(seed) & 1) != 0)) begin
      check_alpha();
      alpha_rd = 1'b1;
    end else begin
      alpha_rd = 1'b0;
    end
  endtask

  task automatic write_table();
    for (int i = 0; i < NUM_GROUPS; i++) begin
      cfg_wr    = 1'b1;
      cfg_addr  = GRP_W'(i);
      cfg_count = CNT_W'(tbl[i]);
      run_cycle();
    end
    cfg_wr = 1'b0;
  endtask

  task automatic random_table();
    for (int i = 0; i < NUM_GROUPS; i++) begin
      tbl[i] = 1 + ($random(seed) & 15);
    end
    write_table();
  endtask

  // alpha = floor(2^e * 2^12 / sum of 2^e)
  task automatic queue_subgraph(input bit equal);
    int     n;
    int     e;
    int     es [$];
    longint sum;
    n   = tbl[grp];
    e   = $random(seed) & 15;
    sum = 0;
    for (int i = 0; i < n; i++) begin
      if (!equal) begin
        e = $random(seed) & 15;
      end
      es.push_back(e);
      sum += longint'(1) << e;
    end
    for (int i = 0; i < n; i++) begin
      send_q.push_back(es[i]);
      exp_q.push_back(int'((longint'(1) << (es[i] + ALPHA_FRAC)) / sum));
    end
    grp        = (grp + 1) % NUM_GROUPS;
    coef_total += n;
    limit      = 2000 + 40 * coef_total;
  endtask

  task automatic drain();
    while (send_q.size() > 0 || exp_q.size() > 0) begin
      run_cycle();
    end
    // anything arriving now is a duplicate
    rd_random = 1'b0;
    repeat (DIV_LAT + 8) run_cycle();
  endtask

  task automatic start_test();
    test_err  = 0;
    rd_hold   = 1'b0;
    rd_random = 1'b0;
    wr_random = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_err == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, test_err);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    coef_din  = '0;
    coef_wr   = 1'b0;
    alpha_rd  = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_count = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    start_test();
    for (int i = 0; i < NUM_GROUPS; i++) begin
      tbl[i] = 1;
    end
    write_table();
    repeat (4) queue_subgraph(1'b0);
    drain();
    finish_test("single node");

    start_test();
    for (int r = 0; r < 5; r++) begin
      random_table();
      repeat (NUM_GROUPS) queue_subgraph(1'b0);
      drain();
    end
    finish_test("random tables");

    start_test();
    random_table();
    repeat (NUM_GROUPS) queue_subgraph(1'b1);
    drain();
    finish_test("equal coefficients");

    // largest subgraphs fill every queue
    start_test();
    for (int i = 0; i < NUM_GROUPS; i++) begin
      tbl[i] = MAX_NODES;
    end
    write_table();
    repeat (NUM_GROUPS) queue_subgraph(1'b0);
    rd_hold   = 1'b1;
    full_seen = 1'b0;
    repeat (300) run_cycle();
    if (!full_seen) begin
      $display("coef_full never rose while the output was held");
      note_error();
    end
    rd_hold = 1'b0;
    drain();
    finish_test("output hold");

    start_test();
    random_table();
    wr_random = 1'b1;
    rd_random = 1'b1;
    repeat (2 * NUM_GROUPS) queue_subgraph(1'b0);
    drain();
    finish_test("random gaps");

    start_test();
    tbl = '{2, 5, 1, 16, 9, 3, 12, 7};
    write_table();
    repeat (NUM_GROUPS) queue_subgraph(1'b0);
    drain();
    finish_test("table rewrite");

    errors += uut.u_softmax.u_chk.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/sm_dim_pkg.sv
rtl/sm_fxp_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/node_count_ram.sv
rtl/fxp_div_pipe.sv
rtl/softmax.sv
rtl/gat_softmax_top.sv
testbench/gat_softmax_chk.sv
testbench/tb_gat_softmax.sv

// File: Bender.yml
package:
  name: gat_softmax

dependencies: {}

sources:
  # design, packages first
  - files:
      - rtl/sm_dim_pkg.sv
      - rtl/sm_fxp_pkg.sv
      - rtl/fifo_if.sv
      - rtl/sync_fifo.sv
      - rtl/node_count_ram.sv
      - rtl/fxp_div_pipe.sv
      - rtl/softmax.sv
      - rtl/gat_softmax_top.sv
  # testbench
  - target: test
    files:
      - testbench/gat_softmax_chk.sv
      - testbench/tb_gat_softmax.sv
